// ==== source/matrix_pkg.sv ====
package matrix_pkg;

    // ------------------------------------------------------------
    // Timing and sizing
    // ------------------------------------------------------------
    // Kept short so the UART runs quickly in simulation
    localparam int CLKS_PER_BIT = 16;
    localparam int MAX_DIM      = 5;
    localparam int SLOT_COUNT   = 5;
    localparam int SEED_COUNT   = 3;

    // ------------------------------------------------------------
    // Types
    // ------------------------------------------------------------
    typedef logic [7:0] byte_t;
    typedef logic [7:0] elem_t;

    // Row or column count, legal values are 1 to MAX_DIM
    typedef logic [2:0] dim_t;
    typedef logic [2:0] slot_t;

    // Row-major, element r*n+c sits at bits [8*(r*n+c) +: 8]
    typedef logic [MAX_DIM*MAX_DIM*8-1:0] matrix_t;

    typedef enum logic [1:0] {
        MODE_IDLE,
        MODE_STORE,
        MODE_SHOW
    } mode_e;

    // ------------------------------------------------------------
    // Demo contents loaded into the store at reset
    // ------------------------------------------------------------
    localparam matrix_t SEED_DATA [SLOT_COUNT] = '{
        200'h04_03_02_01,
        200'h08_07_06_05,
        200'h09_08_07_06_05_04_03_02_01,
        200'h0,
        200'h0
    };

    localparam dim_t SEED_M [SLOT_COUNT] = '{3'd2, 3'd2, 3'd3, 3'd0, 3'd0};
    localparam dim_t SEED_N [SLOT_COUNT] = '{3'd2, 3'd2, 3'd3, 3'd0, 3'd0};

endpackage

// ==== source/uart_rx.sv ====
module uart_rx (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              uart_rx,
    output matrix_pkg::byte_t rx_byte,
    output logic              rx_done
);

    typedef enum logic [1:0] {
        RX_IDLE,
        RX_START,
        RX_DATA,
        RX_STOP
    } rx_state_e;

    localparam int CNT_W = $clog2(matrix_pkg::CLKS_PER_BIT);

    rx_state_e         state;
    logic [CNT_W-1:0]  bit_cnt;
    logic [2:0]        bit_idx;
    matrix_pkg::byte_t shift;
    logic              bit_end;

    assign bit_end = (bit_cnt == CNT_W'(matrix_pkg::CLKS_PER_BIT - 1));

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state   <= RX_IDLE;
            bit_cnt <= '0;
            bit_idx <= '0;
            shift   <= '0;
            rx_byte <= '0;
            rx_done <= 1'b0;
        end else begin
            rx_done <= 1'b0;
            case (state)
                RX_IDLE: begin
                    bit_cnt <= '0;
                    if (!uart_rx) begin
                        state <= RX_START;
                    end
                end
                RX_START: begin
                    // Check the start bit again at its middle to reject glitches
                    if (bit_cnt == CNT_W'(matrix_pkg::CLKS_PER_BIT / 2 - 1)) begin
                        bit_cnt <= '0;
                        bit_idx <= '0;
                        state   <= uart_rx ? RX_IDLE : RX_DATA;
                    end else begin
                        bit_cnt <= bit_cnt + 1'b1;
                    end
                end
                RX_DATA: begin
                    if (bit_end) begin
                        bit_cnt <= '0;
                        shift   <= {uart_rx, shift[7:1]};
                        bit_idx <= bit_idx + 1'b1;
                        if (bit_idx == 3'd7) begin
                            state <= RX_STOP;
                        end
                    end else begin
                        bit_cnt <= bit_cnt + 1'b1;
                    end
                end
                RX_STOP: begin
                    if (bit_end) begin
                        state <= RX_IDLE;
                        // A low stop bit is a framing error and the byte is lost
                        if (uart_rx) begin
                            rx_byte <= shift;
                            rx_done <= 1'b1;
                        end
                    end else begin
                        bit_cnt <= bit_cnt + 1'b1;
                    end
                end
                default: state <= RX_IDLE;
            endcase
        end
    end

endmodule

// ==== source/command_decoder.sv ====
module command_decoder (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                btn,
    input  logic [4:0]          mode_sw,
    input  logic                rx_done,
    input  logic                show_busy,
    input  matrix_pkg::byte_t   rx_byte,
    output matrix_pkg::mode_e   mode,
    output logic                store_we,
    output logic                query_go,
    output matrix_pkg::dim_t    store_m,
    output matrix_pkg::dim_t    store_n,
    output matrix_pkg::dim_t    query_m,
    output matrix_pkg::dim_t    query_n,
    output matrix_pkg::matrix_t store_data
);

    typedef enum logic [1:0] {
        DEC_M,
        DEC_N,
        DEC_ELEM
    } dec_state_e;

    dec_state_e        state;
    logic [4:0]        elem_idx;
    logic [4:0]        elem_total;
    logic              accept;
    logic              dim_ok;
    logic              digit_ok;
    matrix_pkg::elem_t digit;

    // Bytes count only in an active mode and while no answer is going out
    assign accept     = rx_done && !show_busy && !btn && (mode != matrix_pkg::MODE_IDLE);
    assign dim_ok     = (rx_byte >= 8'h31) && (rx_byte < 8'h31 + matrix_pkg::MAX_DIM);
    assign digit_ok   = (rx_byte >= 8'h30) && (rx_byte <= 8'h39);
    assign digit      = rx_byte - 8'h30;
    assign elem_total = 5'(store_m) * 5'(store_n);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mode     <= matrix_pkg::MODE_IDLE;
            state    <= DEC_M;
            elem_idx <= '0;
            store_m  <= '0;
            store_n  <= '0;
            query_m  <= '0;
            query_n  <= '0;
            store_we <= 1'b0;
            query_go <= 1'b0;
        end else begin
            store_we <= 1'b0;
            query_go <= 1'b0;
            if (btn) begin
                // Any press drops a half-received command
                state <= DEC_M;
                if (mode == matrix_pkg::MODE_IDLE) begin
                    case (mode_sw)
                        5'b00001: mode <= matrix_pkg::MODE_STORE;
                        5'b00100: mode <= matrix_pkg::MODE_SHOW;
                        default:  mode <= matrix_pkg::MODE_IDLE;
                    endcase
                end else begin
                    mode <= matrix_pkg::MODE_IDLE;
                end
            end else if (accept) begin
                case (state)
                    DEC_M: begin
                        if (dim_ok) begin
                            store_m <= matrix_pkg::dim_t'(digit);
                            state   <= DEC_N;
                        end
                    end
                    DEC_N: begin
                        if (dim_ok && mode == matrix_pkg::MODE_SHOW) begin
                            query_m  <= store_m;
                            query_n  <= matrix_pkg::dim_t'(digit);
                            query_go <= 1'b1;
                            state    <= DEC_M;
                        end else if (dim_ok) begin
                            store_n  <= matrix_pkg::dim_t'(digit);
                            elem_idx <= '0;
                            state    <= DEC_ELEM;
                        end
                    end
                    DEC_ELEM: begin
                        if (digit_ok && elem_idx == elem_total - 5'd1) begin
                            store_we <= 1'b1;
                            state    <= DEC_M;
                        end else if (digit_ok) begin
                            elem_idx <= elem_idx + 5'd1;
                        end
                    end
                    default: state <= DEC_M;
                endcase
            end
        end
    end

    // Element assembly, cleared when a new matrix begins so unused cells read zero
    always_ff @(posedge clk) begin
        if (accept && state == DEC_M && dim_ok) begin
            store_data <= '0;
        end else if (accept && state == DEC_ELEM && digit_ok) begin
            store_data[8*elem_idx +: 8] <= digit;
        end
    end

endmodule

// ==== source/matrix_store.sv ====
module matrix_store (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                store_we,
    input  matrix_pkg::dim_t    store_m,
    input  matrix_pkg::dim_t    store_n,
    input  matrix_pkg::matrix_t store_data,
    input  matrix_pkg::dim_t    query_m,
    input  matrix_pkg::dim_t    query_n,
    input  matrix_pkg::slot_t   cursor,
    output matrix_pkg::slot_t   match_count,
    output matrix_pkg::matrix_t match_data
);

    matrix_pkg::matrix_t data_mem [matrix_pkg::SLOT_COUNT];
    matrix_pkg::dim_t    m_mem    [matrix_pkg::SLOT_COUNT];
    matrix_pkg::dim_t    n_mem    [matrix_pkg::SLOT_COUNT];
    matrix_pkg::slot_t   fill_count;
    matrix_pkg::slot_t   hit_count;
    matrix_pkg::matrix_t hit_data;

    // ------------------------------------------------------------
    // Slot writes, filled in order and never overwritten
    // ------------------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            data_mem   <= matrix_pkg::SEED_DATA;
            m_mem      <= matrix_pkg::SEED_M;
            n_mem      <= matrix_pkg::SEED_N;
            fill_count <= matrix_pkg::slot_t'(matrix_pkg::SEED_COUNT);
        end else if (store_we && fill_count < matrix_pkg::SLOT_COUNT) begin
            data_mem[fill_count] <= store_data;
            m_mem[fill_count]    <= store_m;
            n_mem[fill_count]    <= store_n;
            fill_count           <= fill_count + 1'b1;
        end
    end

    // ------------------------------------------------------------
    // Lookup by size
    // ------------------------------------------------------------
    // Counts the slots of the queried size and picks the cursor-th one in slot order
    always_comb begin
        hit_count = '0;
        hit_data  = '0;
        for (int i = 0; i < matrix_pkg::SLOT_COUNT; i++) begin
            if (i < fill_count && m_mem[i] == query_m && n_mem[i] == query_n) begin
                if (hit_count == cursor) begin
                    hit_data = data_mem[i];
                end
                hit_count = hit_count + 1'b1;
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            match_count <= '0;
        end else begin
            match_count <= hit_count;
        end
    end

    always_ff @(posedge clk) begin
        match_data <= hit_data;
    end

endmodule

// ==== source/show_sequencer.sv ====
module show_sequencer (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              query_go,
    input  logic              frame_busy,
    input  matrix_pkg::slot_t match_count,
    output matrix_pkg::slot_t cursor,
    output logic              frame_go,
    output logic              show_busy,
    output matrix_pkg::byte_t frame_id
);

    typedef enum logic [1:0] {
        SEQ_IDLE,
        SEQ_PREPARE,
        SEQ_LAUNCH,
        SEQ_WAIT
    } seq_state_e;

    seq_state_e state;

    // Frame ids count from 1 in match order
    assign frame_id = matrix_pkg::byte_t'(cursor) + 8'd1;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= SEQ_IDLE;
            cursor    <= '0;
            frame_go  <= 1'b0;
            show_busy <= 1'b0;
        end else begin
            frame_go <= 1'b0;
            case (state)
                SEQ_IDLE: begin
                    if (query_go) begin
                        cursor    <= '0;
                        show_busy <= 1'b1;
                        state     <= SEQ_PREPARE;
                    end
                end
                SEQ_PREPARE: begin
                    // match_count reflects the new query from this cycle on
                    if (match_count == '0) begin
                        show_busy <= 1'b0;
                        state     <= SEQ_IDLE;
                    end else begin
                        frame_go <= 1'b1;
                        state    <= SEQ_WAIT;
                    end
                end
                SEQ_LAUNCH: begin
                    frame_go <= 1'b1;
                    state    <= SEQ_WAIT;
                end
                SEQ_WAIT: begin
                    // frame_busy only rises the cycle after frame_go
                    if (!frame_busy && !frame_go) begin
                        cursor <= cursor + 1'b1;
                        if (cursor + 1'b1 == match_count) begin
                            show_busy <= 1'b0;
                            state     <= SEQ_IDLE;
                        end else begin
                            state <= SEQ_LAUNCH;
                        end
                    end
                end
                default: state <= SEQ_IDLE;
            endcase
        end
    end

endmodule

// ==== source/frame_serializer.sv ====
module frame_serializer (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                frame_go,
    input  logic                tx_busy,
    input  matrix_pkg::byte_t   frame_id,
    input  matrix_pkg::dim_t    frame_m,
    input  matrix_pkg::dim_t    frame_n,
    input  matrix_pkg::matrix_t frame_data,
    output logic                frame_busy,
    output logic                tx_go,
    output matrix_pkg::byte_t   tx_byte
);

    matrix_pkg::byte_t   id_q;
    matrix_pkg::dim_t    m_q;
    matrix_pkg::dim_t    n_q;
    matrix_pkg::matrix_t data_q;
    logic [4:0]          idx;
    logic [4:0]          frame_len;
    logic                send;

    // Header of id, m and n, then the elements
    assign frame_len = 5'd3 + 5'(m_q) * 5'(n_q);
    assign send      = frame_busy && !frame_go && !tx_busy && !tx_go && (idx != frame_len);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            id_q       <= '0;
            m_q        <= '0;
            n_q        <= '0;
            idx        <= '0;
            frame_busy <= 1'b0;
            tx_go      <= 1'b0;
            tx_byte    <= '0;
        end else begin
            tx_go <= 1'b0;
            if (frame_go) begin
                id_q       <= frame_id;
                m_q        <= frame_m;
                n_q        <= frame_n;
                idx        <= '0;
                frame_busy <= 1'b1;
            end else if (send) begin
                tx_go <= 1'b1;
                idx   <= idx + 5'd1;
                case (idx)
                    5'd0:    tx_byte <= id_q;
                    5'd1:    tx_byte <= matrix_pkg::byte_t'(m_q);
                    5'd2:    tx_byte <= matrix_pkg::byte_t'(n_q);
                    default: tx_byte <= data_q[7:0];
                endcase
            end else if (frame_busy && !tx_busy && !tx_go) begin
                // Last stop bit has ended
                frame_busy <= 1'b0;
            end
        end
    end

    // Elements leave from the low end, which is row-major order
    always_ff @(posedge clk) begin
        if (frame_go) begin
            data_q <= frame_data;
        end else if (send && idx >= 5'd3) begin
            data_q <= data_q >> 8;
        end
    end

endmodule

// ==== source/uart_tx.sv ====
module uart_tx (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              tx_go,
    input  matrix_pkg::byte_t tx_byte,
    output logic              uart_tx,
    output logic              tx_busy
);

    localparam int CNT_W = $clog2(matrix_pkg::CLKS_PER_BIT);

    logic [CNT_W-1:0] cnt;
    logic [3:0]       bit_idx;
    logic [8:0]       shift;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            uart_tx <= 1'b1;
            tx_busy <= 1'b0;
            cnt     <= '0;
            bit_idx <= '0;
            shift   <= '1;
        end else if (tx_go && !tx_busy) begin
            // Start bit goes out now, data and stop bit wait in the shift register
            uart_tx <= 1'b0;
            shift   <= {1'b1, tx_byte};
            tx_busy <= 1'b1;
            cnt     <= '0;
            bit_idx <= '0;
        end else if (tx_busy) begin
            if (cnt == CNT_W'(matrix_pkg::CLKS_PER_BIT - 1)) begin
                cnt <= '0;
                if (bit_idx == 4'd9) begin
                    tx_busy <= 1'b0;
                end else begin
                    uart_tx <= shift[0];
                    shift   <= {1'b1, shift[8:1]};
                    bit_idx <= bit_idx + 4'd1;
                end
            end else begin
                cnt <= cnt + 1'b1;
            end
        end
    end

endmodule

// ==== source/matrix_show_top.sv ====
module matrix_show_top (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       btn,
    input  logic       uart_rx,
    input  logic [4:0] mode_sw,
    output logic       uart_tx
);

    matrix_pkg::byte_t   rx_byte;
    logic                rx_done;
    logic                store_we;
    logic                query_go;
    matrix_pkg::dim_t    store_m;
    matrix_pkg::dim_t    store_n;
    matrix_pkg::dim_t    query_m;
    matrix_pkg::dim_t    query_n;
    matrix_pkg::matrix_t store_data;
    matrix_pkg::slot_t   cursor;
    matrix_pkg::slot_t   match_count;
    matrix_pkg::matrix_t match_data;
    logic                frame_go;
    logic                frame_busy;
    logic                show_busy;
    matrix_pkg::byte_t   frame_id;
    logic                tx_go;
    logic                tx_busy;
    matrix_pkg::byte_t   tx_byte;

    // ------------------------------------------------------------
    // Decode
    // ------------------------------------------------------------
    uart_rx u_uart_rx (
        .clk     (clk),
        .rst_n   (rst_n),
        .uart_rx (uart_rx),
        .rx_byte (rx_byte),
        .rx_done (rx_done)
    );

    command_decoder u_command_decoder (
        .clk        (clk),
        .rst_n      (rst_n),
        .btn        (btn),
        .mode_sw    (mode_sw),
        .rx_done    (rx_done),
        .show_busy  (show_busy),
        .rx_byte    (rx_byte),
        .mode       (),
        .store_we   (store_we),
        .query_go   (query_go),
        .store_m    (store_m),
        .store_n    (store_n),
        .query_m    (query_m),
        .query_n    (query_n),
        .store_data (store_data)
    );

    // ------------------------------------------------------------
    // Execute
    // ------------------------------------------------------------
    matrix_store u_matrix_store (
        .clk         (clk),
        .rst_n       (rst_n),
        .store_we    (store_we),
        .store_m     (store_m),
        .store_n     (store_n),
        .store_data  (store_data),
        .query_m     (query_m),
        .query_n     (query_n),
        .cursor      (cursor),
        .match_count (match_count),
        .match_data  (match_data)
    );

    show_sequencer u_show_sequencer (
        .clk         (clk),
        .rst_n       (rst_n),
        .query_go    (query_go),
        .frame_busy  (frame_busy),
        .match_count (match_count),
        .cursor      (cursor),
        .frame_go    (frame_go),
        .show_busy   (show_busy),
        .frame_id    (frame_id)
    );

    // ------------------------------------------------------------
    // Result
    // ------------------------------------------------------------
    // Frame size comes straight from the query that selected the matches
    frame_serializer u_frame_serializer (
        .clk        (clk),
        .rst_n      (rst_n),
        .frame_go   (frame_go),
        .tx_busy    (tx_busy),
        .frame_id   (frame_id),
        .frame_m    (query_m),
        .frame_n    (query_n),
        .frame_data (match_data),
        .frame_busy (frame_busy),
        .tx_go      (tx_go),
        .tx_byte    (tx_byte)
    );

    uart_tx u_uart_tx (
        .clk     (clk),
        .rst_n   (rst_n),
        .tx_go   (tx_go),
        .tx_byte (tx_byte),
        .uart_tx (uart_tx),
        .tx_busy (tx_busy)
    );

endmodule

// ==== test/matrix_show_checker.sv ====
module matrix_show_checker (
    input logic              clk,
    input logic              rst_n,
    input logic              uart_tx,
    input logic              rx_done,
    input logic              frame_go,
    input logic              frame_busy,
    input logic              tx_go,
    input logic              tx_busy,
    input matrix_pkg::slot_t fill_count
);

    int fail_count = 0;

    // ------------------------------------------------------------
    // Serial line and strobes
    // ------------------------------------------------------------
    // Outside a frame the transmit line must idle high
    a_line_idle: assert property (@(posedge clk) disable iff (!rst_n)
        !frame_busy |-> uart_tx)
    else begin
        $error("uart_tx low while no frame is being sent");
        fail_count++;
    end

    a_rx_done_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        rx_done |=> !rx_done)
    else begin
        $error("rx_done held for more than one cycle");
        fail_count++;
    end

    a_frame_go_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        frame_go |=> !frame_go)
    else begin
        $error("frame_go held for more than one cycle");
        fail_count++;
    end

    // The transmitter would drop a byte started while it is busy
    a_tx_go_idle: assert property (@(posedge clk) disable iff (!rst_n)
        tx_go |-> !tx_busy)
    else begin
        $error("tx_go asserted while tx_busy is high");
        fail_count++;
    end

    a_fill_limit: assert property (@(posedge clk) disable iff (!rst_n)
        fill_count <= matrix_pkg::SLOT_COUNT)
    else begin
        $error("store fill count exceeds the slot count");
        fail_count++;
    end

endmodule

bind matrix_show_top matrix_show_checker u_matrix_show_checker (
    .clk        (clk),
    .rst_n      (rst_n),
    .uart_tx    (uart_tx),
    .rx_done    (rx_done),
    .frame_go   (frame_go),
    .frame_busy (frame_busy),
    .tx_go      (tx_go),
    .tx_busy    (tx_busy),
    .fill_count (u_matrix_store.fill_count)
);

// ==== test/matrix_show_tb.sv ====
module matrix_show_tb;

    localparam int BIT_CLKS   = matrix_pkg::CLKS_PER_BIT;
    // Long enough to cover a few request bytes before the reply starts
    localparam int RX_TIMEOUT = 80 * BIT_CLKS;
    localparam int IDLE_CLKS  = 30 * BIT_CLKS;

    logic       clk;
    logic       rst_n;
    logic       btn;
    logic       ser_in;
    logic [4:0] mode_sw;
    logic       ser_out;

    int mismatches;
    int timeouts;

    // Reference copy of the store contents, in slot order
    int                model_fill;
    matrix_pkg::byte_t model_m     [matrix_pkg::SLOT_COUNT];
    matrix_pkg::byte_t model_n     [matrix_pkg::SLOT_COUNT];
    matrix_pkg::byte_t model_elems [matrix_pkg::SLOT_COUNT][25];

    matrix_show_top u_matrix_show_top (
        .clk     (clk),
        .rst_n   (rst_n),
        .btn     (btn),
        .uart_rx (ser_in),
        .mode_sw (mode_sw),
        .uart_tx (ser_out)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // ------------------------------------------------------------
    // Reference model
    // ------------------------------------------------------------
    function automatic void seed_model();
        model_fill = 3;
        model_m[0] = 8'd2;
        model_n[0] = 8'd2;
        model_m[1] = 8'd2;
        model_n[1] = 8'd2;
        model_m[2] = 8'd3;
        model_n[2] = 8'd3;
        for (int k = 0; k < 4; k++) begin
            model_elems[0][k] = matrix_pkg::byte_t'(k + 1);
            model_elems[1][k] = matrix_pkg::byte_t'(k + 5);
        end
        for (int k = 0; k < 9; k++) begin
            model_elems[2][k] = matrix_pkg::byte_t'(k + 1);
        end
    endfunction

    // Writes past the last slot are lost, as in the store
    function automatic void model_store(input matrix_pkg::byte_t m, input matrix_pkg::byte_t n,
                                        input matrix_pkg::byte_t elems[$]);
        if (model_fill < matrix_pkg::SLOT_COUNT) begin
            model_m[model_fill] = m;
            model_n[model_fill] = n;
            foreach (elems[i]) begin
                model_elems[model_fill][i] = elems[i];
            end
            model_fill++;
        end
    endfunction

    function automatic void build_reply(input matrix_pkg::byte_t m, input matrix_pkg::byte_t n,
                                        output matrix_pkg::byte_t reply[$]);
        int id;
        reply = {};
        id    = 0;
        for (int s = 0; s < model_fill; s++) begin
            if (model_m[s] == m && model_n[s] == n) begin
                id++;
                reply.push_back(matrix_pkg::byte_t'(id));
                reply.push_back(m);
                reply.push_back(n);
                for (int k = 0; k < m * n; k++) begin
                    reply.push_back(model_elems[s][k]);
                end
            end
        end
    endfunction

    // ------------------------------------------------------------
    // Pin-level drivers and receiver
    // ------------------------------------------------------------
    task automatic apply_reset();
        @(negedge clk);
        rst_n = 1'b0;
        repeat (5) @(negedge clk);
        rst_n = 1'b1;
    endtask

    task automatic press_button(input logic [4:0] sw);
        @(negedge clk);
        mode_sw = sw;
        btn     = 1'b1;
        @(negedge clk);
        btn     = 1'b0;
    endtask

    task automatic send_byte(input matrix_pkg::byte_t value);
        @(negedge clk);
        ser_in = 1'b0;
        repeat (BIT_CLKS) @(negedge clk);
        for (int i = 0; i < 8; i++) begin
            ser_in = value[i];
            repeat (BIT_CLKS) @(negedge clk);
        end
        ser_in = 1'b1;
        repeat (BIT_CLKS) @(negedge clk);
    endtask

    // Samples at falling edges, half a bit after the start edge and then once per bit
    task automatic recv_byte(output matrix_pkg::byte_t value, output bit ok);
        int waited;
        waited = 0;
        value  = '0;
        ok     = 1'b0;
        while (ser_out !== 1'b0 && waited < RX_TIMEOUT) begin
            @(negedge clk);
            waited++;
        end
        if (ser_out !== 1'b0) begin
            $display("timeout at %0t: no start bit seen on uart_tx", $time);
            timeouts++;
            return;
        end
        repeat (BIT_CLKS / 2) @(negedge clk);
        assert (ser_out === 1'b0) else begin
            $display("mismatch %0t: start bit did not last half a bit", $time);
            mismatches++;
        end
        for (int i = 0; i < 8; i++) begin
            repeat (BIT_CLKS) @(negedge clk);
            value[i] = ser_out;
        end
        repeat (BIT_CLKS) @(negedge clk);
        assert (ser_out === 1'b1) else begin
            $display("mismatch %0t: stop bit is low", $time);
            mismatches++;
        end
        ok = 1'b1;
    endtask

    task automatic collect_bytes(input matrix_pkg::byte_t exp_q[$]);
        matrix_pkg::byte_t got;
        bit                ok;
        foreach (exp_q[i]) begin
            recv_byte(got, ok);
            if (!ok) begin
                return;
            end
            assert (got == exp_q[i]) else begin
                $display("mismatch %0t: reply byte %0d is %0d, expected %0d",
                         $time, i, got, exp_q[i]);
                mismatches++;
            end
        end
    endtask

    // Any start bit in this window is output that no request asked for
    task automatic check_line_idle();
        int waited;
        waited = 0;
        while (ser_out === 1'b1 && waited < IDLE_CLKS) begin
            @(negedge clk);
            waited++;
        end
        assert (ser_out === 1'b1) else begin
            $display("mismatch %0t: uart_tx left idle when no reply was due", $time);
            mismatches++;
        end
    endtask

    task automatic run_exchange(input matrix_pkg::byte_t send_q[$],
                                input matrix_pkg::byte_t exp_q[$]);
        fork
            begin
                foreach (send_q[i]) begin
                    send_byte(send_q[i]);
                end
            end
            collect_bytes(exp_q);
        join
        check_line_idle();
    endtask

    // ------------------------------------------------------------
    // Commands
    // ------------------------------------------------------------
    task automatic store_matrix(input matrix_pkg::byte_t m, input matrix_pkg::byte_t n,
                                input matrix_pkg::byte_t elems[$]);
        matrix_pkg::byte_t send_q[$];
        matrix_pkg::byte_t none[$];
        send_q.push_back(8'h30 + m);
        send_q.push_back(8'h30 + n);
        foreach (elems[i]) begin
            send_q.push_back(8'h30 + elems[i]);
        end
        run_exchange(send_q, none);
        model_store(m, n, elems);
    endtask

    task automatic show_query(input matrix_pkg::byte_t junk[$], input matrix_pkg::byte_t m,
                              input matrix_pkg::byte_t n);
        matrix_pkg::byte_t send_q[$];
        matrix_pkg::byte_t reply[$];
        send_q = junk;
        send_q.push_back(8'h30 + m);
        send_q.push_back(8'h30 + n);
        build_reply(m, n, reply);
        run_exchange(send_q, reply);
    endtask

    initial begin
        matrix_pkg::byte_t none[$];
        matrix_pkg::byte_t junk[$];
        matrix_pkg::byte_t elems[$];
        int                checker_fails;

        rst_n      = 1'b0;
        btn        = 1'b0;
        ser_in     = 1'b1;
        mode_sw    = 5'b00000;
        mismatches = 0;
        timeouts   = 0;
        seed_model();
        apply_reset();

        // Two switches at once is not a mode, so the digits go nowhere
        press_button(5'b00101);
        junk = '{8'h32, 8'h32};
        run_exchange(junk, none);
        junk.delete();

        press_button(5'b00100);
        show_query(junk, 8'd2, 8'd2);
        show_query(junk, 8'd3, 8'd3);
        show_query(junk, 8'd4, 8'd4);
        // 'x' and '7' are not dimension digits
        junk = '{8'h78, 8'h37};
        show_query(junk, 8'd3, 8'd3);
        junk.delete();

        // Back to idle, then STORE
        press_button(5'b00100);
        press_button(5'b00001);
        elems = '{8'd9, 8'd8, 8'd7, 8'd6};
        store_matrix(8'd2, 8'd2, elems);
        press_button(5'b00100);
        press_button(5'b00100);
        show_query(junk, 8'd2, 8'd2);

        // Fresh store with two free slots for the overflow case
        apply_reset();
        seed_model();
        press_button(5'b00001);
        elems = '{8'd4};
        store_matrix(8'd1, 8'd1, elems);
        elems = '{8'd5};
        store_matrix(8'd1, 8'd1, elems);
        elems = '{8'd6};
        store_matrix(8'd1, 8'd1, elems);
        press_button(5'b00100);
        press_button(5'b00100);
        show_query(junk, 8'd1, 8'd1);

        checker_fails = u_matrix_show_top.u_matrix_show_checker.fail_count;
        $display("errors: %0d mismatches, %0d timeouts, %0d checker failures",
                 mismatches, timeouts, checker_fails);
        if (mismatches == 0 && timeouts == 0 && checker_fails == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

// ==== sim.f ====
source/matrix_pkg.sv
source/uart_rx.sv
source/command_decoder.sv
source/matrix_store.sv
source/show_sequencer.sv
source/frame_serializer.sv
source/uart_tx.sv
source/matrix_show_top.sv
test/matrix_show_checker.sv
test/matrix_show_tb.sv

// ==== Bender.yml ====
package:
  name: matrix_show

sources:
  - source/matrix_pkg.sv
  - source/uart_rx.sv
  - source/command_decoder.sv
  - source/matrix_store.sv
  - source/show_sequencer.sv
  - source/frame_serializer.sv
  - source/uart_tx.sv
  - source/matrix_show_top.sv
  - target: test
    files:
      - test/matrix_show_checker.sv
      - test/matrix_show_tb.sv
